// File: xip.f
+incdir+.
xip_pkg.sv
xip_regs.sv
xip_fetch.sv
xip_spi_phy.sv
xip_top.sv
xip_tb_clkgen.sv
xip_properties.sv
xip_tb.sv

// File: Bender.yml
package:
  name: xip

sources:
  - include_dirs:
      - .
    files:
      - xip_pkg.sv
      - xip_regs.sv
      - xip_fetch.sv
      - xip_spi_phy.sv
      - xip_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - xip_tb_clkgen.sv
      - xip_properties.sv
      - xip_tb.sv

// File: xip_tb.sv
// testbench for the XIP controller, flash model answers cpha 0 reads with
// mem(a) = a[7:0] ^ 5A, its address length follows cfg_abytes
`timescale 1ns/1ns
`include "xip_macros.svh"

module xip_tb;

    localparam logic [3:0] PAGE      = 4'h9;                 // fetch page under test
    localparam int         N_READS   = 6;                    // reads per fetch mode
    localparam int         FRAME_CYC = 9 * 8 * 2 * 4 + 16;   // nine bytes at prsc 3
    localparam int         N_TESTS   = 4 * N_READS + 10;
    localparam int         WD_NS     = 2 * N_TESTS * FRAME_CYC * 4 + 200;

    logic                   clk_i;
    logic                   rstn_i;
    xip_pkg::reg_idx_e      ct_idx_i;
    logic                   ct_rden_i;
    logic                   ct_wren_i;
    logic [`XIP_DATA_W-1:0] ct_data_i;
    logic [`XIP_DATA_W-1:0] ct_data_o;
    logic                   ct_ack_o;
    logic [`XIP_DATA_W-1:0] acc_addr_i;
    logic                   acc_rden_i;
    logic                   acc_wren_i;
    logic [`XIP_DATA_W-1:0] acc_data_o;
    logic                   acc_ack_o;
    logic                   acc_err_o;
    logic                   xip_acc_o;
    logic                   spi_csn_o;
    logic                   spi_clk_o;
    logic                   spi_dat_i;
    logic                   spi_dat_o;

    integer      seed;
    int          errors;
    logic [31:0] exp_q[$];        // expected fetch words in order
    logic        err_expected;
    logic        cfg_cpol;        // mirrors the written control word
    logic [1:0]  cfg_abytes;
    logic [31:0] rd;
    logic [31:0] rnd;
    logic [31:0] daddr;
    logic [2:0]  prsc_tab[3] = '{3'd0, 3'd1, 3'd3};
    logic [1:0]  ab_tab[3]   = '{2'd2, 2'd3, 2'd0};
    int          fl_bits;         // flash model frame state
    int          fl_hdr;
    int          fl_d;
    logic [7:0]  fl_cmd;
    logic [7:0]  fl_byte;
    logic [31:0] fl_addr;

    xip_tb_clkgen i_xip_tb_clkgen (.clk_o(clk_i));

    xip_top i_xip_top (.*);

    // ------------------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------------------
    function automatic logic [7:0] flash_byte(input logic [31:0] a);
        return a[7:0] ^ 8'h5A;
    endfunction

    function automatic logic [31:0] flash_addr_of(input logic [31:0] addr,
                                                  input logic [1:0]  ab);
        logic [31:0] wa;
        wa = {4'h0, addr[27:2], 2'b00};                  // page nibble never sent
        return wa & (32'hFFFF_FFFF >> (8 * (3 - ab)));   // keep ab+1 bytes
    endfunction

    function automatic logic [31:0] expected_word(input logic [31:0] addr,
                                                  input logic [1:0]  ab);
        logic [31:0] fa;
        logic [31:0] w;
        fa = flash_addr_of(addr, ab);
        for (int k = 0; k < 4; k++) begin
            w[8*k +: 8] = flash_byte(fa + k);  // little endian, first byte low
        end
        return w;
    endfunction

    function automatic logic [31:0] byte_swap(input logic [31:0] w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

    function automatic logic [31:0] pack_ctrl(input logic [2:0] prsc, input logic cpol,
                                              input logic [3:0] nbytes, input logic xip_en,
                                              input logic [1:0] abytes);
        xip_pkg::xip_ctrl_t c;
        c        = '0;
        c.enable = 1'b1;
        c.csen   = 1'b1;
        c.page   = PAGE;
        c.rd_cmd = 8'h03;  // plain read, no dummy cycles
        c.prsc   = prsc;
        c.cpol   = cpol;
        c.nbytes = nbytes;
        c.xip_en = xip_en;
        c.abytes = abytes;
        return {{(`XIP_DATA_W-`XIP_CTRL_W){1'b0}}, c};
    endfunction

    // ------------------------------------------------------------------------
    // flash model, samples si on the leading edge, drives so on the trailing
    // ------------------------------------------------------------------------
    always @(negedge spi_csn_o) begin
        fl_bits = 0;
        fl_cmd  = '0;
        fl_addr = '0;
        fl_hdr  = 8 + 8 * (cfg_abytes + 1);  // opcode plus address bits
    end

    always @(spi_clk_o) begin
        if (spi_csn_o === 1'b0) begin
            if ((spi_clk_o ^ cfg_cpol) == 1'b1) begin
                if (fl_bits < 8) begin
                    fl_cmd = {fl_cmd[6:0], spi_dat_o};
                end else if (fl_bits < fl_hdr) begin
                    fl_addr = {fl_addr[30:0], spi_dat_o};
                end
                fl_bits++;
            end else if (fl_bits >= fl_hdr) begin
                fl_d      = fl_bits - fl_hdr;  // data bits already out
                fl_byte   = flash_byte(fl_addr + fl_d / 8);
                spi_dat_i <= #1 fl_byte[7 - fl_d % 8];
            end
        end
    end

    // ------------------------------------------------------------------------
    // host tasks, entered and left 1 ns after a rising edge
    // ------------------------------------------------------------------------
    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("Fail %0t ns %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic write_reg(input xip_pkg::reg_idx_e idx, input logic [31:0] data);
        ct_idx_i  = idx;
        ct_data_i = data;
        ct_wren_i = 1'b1;
        @(posedge clk_i);
        check_value("ct_ack_o", ct_ack_o, 32'd0);  // not before the next cycle
        #1 ct_wren_i = 1'b0;
        @(posedge clk_i);
        check_value("ct_ack_o", ct_ack_o, 32'd1);
        #1;
    endtask

    task automatic read_reg(input xip_pkg::reg_idx_e idx, output logic [31:0] data);
        ct_idx_i  = idx;
        ct_rden_i = 1'b1;
        @(posedge clk_i);
        check_value("ct_ack_o", ct_ack_o, 32'd0);
        #1 ct_rden_i = 1'b0;
        @(posedge clk_i);
        check_value("ct_ack_o", ct_ack_o, 32'd1);
        data = ct_data_o;  // valid in the ack cycle only
        #1;
    endtask

    task automatic set_mode(input logic [2:0] prsc, input logic cpol, input logic [3:0] nb,
                            input logic xip_en, input logic [1:0] ab);
        cfg_cpol   = cpol;
        cfg_abytes = ab;
        write_reg(xip_pkg::REG_CTRL, pack_ctrl(prsc, cpol, nb, xip_en, ab));
    endtask

    task automatic wait_direct_done();
        logic [31:0] st;
        logic        busy_seen;
        int          n;
        n = 0;
        read_reg(xip_pkg::REG_CTRL, st);
        busy_seen = st[`XIP_STAT_PHY_BUSY];
        while (st[`XIP_STAT_PHY_BUSY] && n < FRAME_CYC) begin
            read_reg(xip_pkg::REG_CTRL, st);
            n++;
        end
        if (!busy_seen) begin
            errors++;
            $display("direct transfer never showed the phy busy bit");
        end
        if (st[`XIP_STAT_PHY_BUSY]) begin
            errors++;
            $display("direct transfer did not finish in time");
        end
    endtask

    task automatic fetch_word(input logic [31:0] addr);
        logic seen;
        int   n;
        exp_q.push_back(expected_word(addr, cfg_abytes));
        acc_addr_i = addr;
        acc_rden_i = 1'b1;
        seen       = 1'b0;
        n          = 0;
        while (!seen && n < FRAME_CYC) begin
            @(posedge clk_i);
            seen = acc_ack_o;
            n++;
        end
        if (!seen) begin
            errors++;
            $display("no fetch acknowledge for address %h", addr);
            exp_q.delete();
        end else begin
            check_value("flash opcode", fl_cmd, 32'h03);
            check_value("flash address", fl_addr, flash_addr_of(addr, cfg_abytes));
            check_value("spi_clk_o", spi_clk_o, cfg_cpol);  // back at idle level
            check_value("xip_acc_o", xip_acc_o, 32'd1);     // fetch still in flight
        end
        #1 acc_rden_i = 1'b0;
    endtask

    task automatic try_fetch_write(input logic [31:0] addr);
        err_expected = 1'b1;
        acc_addr_i   = addr;
        acc_wren_i   = 1'b1;
        @(posedge clk_i);
        check_value("acc_err_o", acc_err_o, 32'd0);
        #1 acc_wren_i = 1'b0;
        @(posedge clk_i);
        check_value("acc_err_o", acc_err_o, 32'd1);  // exactly one cycle later
        check_value("acc_ack_o", acc_ack_o, 32'd0);
        @(posedge clk_i);
        check_value("acc_err_o", acc_err_o, 32'd0);
        check_value("acc_ack_o", acc_ack_o, 32'd0);
        #1 err_expected = 1'b0;
    endtask

    task automatic probe_off_page(input logic [31:0] addr);
        acc_addr_i = addr;
        acc_rden_i = 1'b1;
        repeat (200) begin
            @(posedge clk_i);
            if (acc_ack_o || acc_err_o) begin
                errors++;
                $display("read outside the page got an answer at %0t ns", $time);
            end
        end
        #1 acc_rden_i = 1'b0;
    endtask

    // ------------------------------------------------------------------------
    // compare process for the fetch port
    // ------------------------------------------------------------------------
    always @(posedge clk_i) begin
        if (rstn_i) begin
            if (acc_ack_o) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("fetch acknowledge with no read pending at %0t ns", $time);
                end else begin
                    check_value("acc_data_o", acc_data_o, exp_q.pop_front());
                end
            end
            if (acc_err_o && !err_expected) begin
                errors++;
                $display("unexpected fetch error pulse at %0t ns", $time);
            end
        end
    end

    initial begin
        #(WD_NS);
        $display("watchdog expired after %0d ns, the run did not complete", WD_NS);
        $display("** FAIL **");
        $finish;
    end

    // ------------------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------------------
    initial begin
        seed         = 32'h8665;
        errors       = 0;
        err_expected = 1'b0;
        cfg_cpol     = 1'b0;
        cfg_abytes   = 2'd0;
        ct_idx_i     = xip_pkg::REG_CTRL;
        ct_rden_i    = 1'b0;
        ct_wren_i    = 1'b0;
        ct_data_i    = '0;
        acc_addr_i   = '0;
        acc_rden_i   = 1'b0;
        acc_wren_i   = 1'b0;
        spi_dat_i    = 1'b0;
        rstn_i       = 1'b0;
        repeat (16) @(posedge clk_i);
        #1 rstn_i = 1'b1;
        @(posedge clk_i);
        #1;

        // register readback, 26 bits kept, bit 5 reserved, idle status zero
        write_reg(xip_pkg::REG_CTRL, 32'hFFFF_FFFF);
        read_reg(xip_pkg::REG_CTRL, rd);
        check_value("ct_data_o", rd, 32'h03FF_FFDF);
        rnd = $random(seed);
        write_reg(xip_pkg::REG_CTRL, rnd);
        read_reg(xip_pkg::REG_CTRL, rd);
        check_value("ct_data_o", rd, rnd & 32'h03FF_FFDF);
        read_reg(xip_pkg::REG_STAT_RSVD, rd);
        check_value("ct_data_o", rd, 32'd0);
        read_reg(xip_pkg::REG_DATA_HI, rd);
        check_value("ct_data_o", rd, 32'd0);  // write only

        // direct frame, opcode 03, 3 address bytes, 4 data bytes
        rnd   = $random(seed);
        daddr = {8'h00, rnd[23:2], 2'b00};
        set_mode(3'd1, 1'b0, 4'd8, 1'b0, 2'd2);
        write_reg(xip_pkg::REG_DATA_LO, 32'd0);
        write_reg(xip_pkg::REG_DATA_HI, {8'h03, daddr[23:0]});
        wait_direct_done();
        read_reg(xip_pkg::REG_DATA_LO, rd);
        check_value("ct_data_o", rd, byte_swap(expected_word(daddr, 2'd2)));
        check_value("flash address", fl_addr, daddr);

        // enable dropped in the middle of a direct frame
        write_reg(xip_pkg::REG_DATA_HI, {8'h03, daddr[23:0]});
        repeat (8) @(posedge clk_i);
        #1;
        write_reg(xip_pkg::REG_CTRL, 32'd0);
        @(posedge clk_i);
        check_value("spi_csn_o", spi_csn_o, 32'd1);  // frame aborted
        #1;

        // xip reads over address lengths and prescalers
        for (int m = 0; m < 3; m++) begin
            set_mode(prsc_tab[m], 1'b0, {2'b00, ab_tab[m]} + 4'd6, 1'b1, ab_tab[m]);
            repeat (N_READS) begin
                rnd = $random(seed);
                fetch_word({PAGE, rnd[27:0]});
            end
        end

        // fetch write and off page read
        rnd = $random(seed);
        try_fetch_write({PAGE, rnd[27:0]});
        probe_off_page({PAGE ^ 4'h5, rnd[27:0]});

        // clock idles high with cpol set
        set_mode(3'd2, 1'b1, 4'd9, 1'b1, 2'd3);
        repeat (4) @(posedge clk_i);
        check_value("spi_clk_o", spi_clk_o, 32'd1);
        #1;
        repeat (N_READS) begin
            rnd = $random(seed);
            fetch_word({PAGE, rnd[27:0]});
        end
        repeat (4) @(posedge clk_i);

        errors += i_xip_top.i_xip_properties.assert_fails;
        $display("run complete, errors: %0d", errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: xip_properties.sv
// protocol rules of the XIP top level, bound into xip_top
// ctrl is the internal control struct, chip select may lag enable by one cycle
`timescale 1ns/1ns

module xip_properties (
    input logic               clk_i,
    input logic               rstn_i,
    input logic               ct_rden_i,
    input logic               ct_wren_i,
    input logic               ct_ack_i,
    input logic               acc_ack_i,
    input logic               acc_err_i,
    input logic               spi_csn_i,
    input xip_pkg::xip_ctrl_t ctrl_i
);

    int assert_fails = 0;  // read by the testbench at the end

    // ------------------------------------------------------------------------
    // control port
    // ------------------------------------------------------------------------
    ack_after_strobe: assert property (@(posedge clk_i) disable iff (!rstn_i)
        ct_ack_i |-> $past(ct_rden_i || ct_wren_i))
    else begin
        $error("control ack without a strobe in the cycle before");
        assert_fails++;
    end

    strobe_gets_ack: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (ct_rden_i || ct_wren_i) |=> ct_ack_i)
    else begin
        $error("control strobe not acknowledged one cycle later");
        assert_fails++;
    end

    // ------------------------------------------------------------------------
    // fetch port and spi pins
    // ------------------------------------------------------------------------
    ack_err_exclusive: assert property (@(posedge clk_i) disable iff (!rstn_i)
        !(acc_ack_i && acc_err_i))
    else begin
        $error("fetch ack and error high in the same cycle");
        assert_fails++;
    end

    csn_high_when_off: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (!ctrl_i.enable ##1 !ctrl_i.enable) |-> spi_csn_i)  // one cycle to abort
    else begin
        $error("chip select low while the block is disabled");
        assert_fails++;
    end

endmodule

bind xip_top xip_properties i_xip_properties (
    .clk_i     (clk_i),
    .rstn_i    (rstn_i),
    .ct_rden_i (ct_rden_i),
    .ct_wren_i (ct_wren_i),
    .ct_ack_i  (ct_ack_o),
    .acc_ack_i (acc_ack_o),
    .acc_err_i (acc_err_o),
    .spi_csn_i (spi_csn_o),
    .ctrl_i    (ctrl)
);

// File: xip_tb_clkgen.sv
// free running testbench clock, 4 ns period, starts low
`timescale 1ns/1ns

module xip_tb_clkgen (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever begin
            #2 clk_o = ~clk_o;  // half period
        end
    end

endmodule

// File: xip_top.sv
// XIP flash controller top, control port plus read-only fetch port
// no back-pressure, the host waits for ack or err
`timescale 1ns/1ns
`include "xip_macros.svh"

module xip_top (
    input  logic                   clk_i,
    input  logic                   rstn_i,
    input  xip_pkg::reg_idx_e      ct_idx_i,
    input  logic                   ct_rden_i,
    input  logic                   ct_wren_i,
    input  logic [`XIP_DATA_W-1:0] ct_data_i,
    output logic [`XIP_DATA_W-1:0] ct_data_o,
    output logic                   ct_ack_o,
    input  logic [`XIP_DATA_W-1:0] acc_addr_i,
    input  logic                   acc_rden_i,
    input  logic                   acc_wren_i,
    output logic [`XIP_DATA_W-1:0] acc_data_o,
    output logic                   acc_ack_o,
    output logic                   acc_err_o,
    output logic                   xip_acc_o,   // fetch in flight
    output logic                   spi_csn_o,
    output logic                   spi_clk_o,
    input  logic                   spi_dat_i,
    output logic                   spi_dat_o
);

    xip_pkg::xip_ctrl_t       ctrl;
    xip_pkg::spi_req_t        spi_req;
    xip_pkg::spi_rsp_t        spi_rsp;
    logic                     direct_start;
    logic [2*`XIP_DATA_W-1:0] direct_frame;

    xip_regs i_xip_regs (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .ct_idx_i       (ct_idx_i),
        .ct_rden_i      (ct_rden_i),
        .ct_wren_i      (ct_wren_i),
        .ct_data_i      (ct_data_i),
        .spi_rsp_i      (spi_rsp),
        .fetch_busy_i   (xip_acc_o),  // xip busy status bit
        .ct_data_o      (ct_data_o),
        .ct_ack_o       (ct_ack_o),
        .ctrl_o         (ctrl),
        .direct_start_o (direct_start),
        .direct_frame_o (direct_frame)
    );

    xip_fetch i_xip_fetch (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .ctrl_i         (ctrl),
        .direct_start_i (direct_start),
        .direct_frame_i (direct_frame),
        .acc_addr_i     (acc_addr_i),
        .acc_rden_i     (acc_rden_i),
        .acc_wren_i     (acc_wren_i),
        .spi_rsp_i      (spi_rsp),
        .spi_req_o      (spi_req),
        .acc_data_o     (acc_data_o),
        .acc_ack_o      (acc_ack_o),
        .acc_err_o      (acc_err_o),
        .fetch_busy_o   (xip_acc_o)
    );

    xip_spi_phy i_xip_spi_phy (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .ctrl_i    (ctrl),
        .spi_req_i (spi_req),
        .spi_dat_i (spi_dat_i),
        .spi_rsp_o (spi_rsp),
        .spi_csn_o (spi_csn_o),
        .spi_clk_o (spi_clk_o),
        .spi_dat_o (spi_dat_o)
    );

endmodule

// File: xip_spi_phy.sv
// spi mode 0/2 engine, cpha 0 only, nbytes*8 bits per frame msb first
// chip select only asserts with csen, the frame aborts when enable drops
`timescale 1ns/1ns
`include "xip_macros.svh"

module xip_spi_phy (
    input  logic               clk_i,
    input  logic               rstn_i,
    input  xip_pkg::xip_ctrl_t ctrl_i,
    input  xip_pkg::spi_req_t  spi_req_i,
    input  logic               spi_dat_i,   // flash so
    output xip_pkg::spi_rsp_t  spi_rsp_o,
    output logic               spi_csn_o,
    output logic               spi_clk_o,
    output logic               spi_dat_o    // flash si
);

    logic                    busy_q;
    logic                    csn_q;
    logic                    phase_q;     // 0 idle level half, 1 active half
    logic [2:0]              prsc_cnt_q;  // cycles in current half bit
    logic [6:0]              bit_cnt_q;   // bits still to go
    logic [`XIP_WDATA_W-1:0] tx_q;
    logic [`XIP_DATA_W-1:0]  rx_q;
    logic                    tick;        // end of half bit
    logic                    start_ok;
    logic                    sample_en;
    logic                    shift_en;

    assign tick      = (prsc_cnt_q == ctrl_i.prsc);
    assign start_ok  = ctrl_i.enable && !busy_q && spi_req_i.start;
    assign sample_en = ctrl_i.enable && busy_q && (bit_cnt_q != '0) && tick && !phase_q;
    assign shift_en  = ctrl_i.enable && busy_q && (bit_cnt_q != '0) && tick && phase_q;

    // ------------------------------------------------------------------------
    // bit timing and chip select
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            busy_q     <= 1'b0;
            csn_q      <= 1'b1;
            phase_q    <= 1'b0;
            prsc_cnt_q <= '0;
            bit_cnt_q  <= '0;
        end else if (!ctrl_i.enable) begin  // held idle
            busy_q     <= 1'b0;
            csn_q      <= 1'b1;
            phase_q    <= 1'b0;
            prsc_cnt_q <= '0;
            bit_cnt_q  <= '0;
        end else if (!busy_q) begin
            phase_q    <= 1'b0;
            prsc_cnt_q <= '0;
            if (spi_req_i.start) begin
                busy_q    <= 1'b1;
                csn_q     <= !ctrl_i.csen;
                bit_cnt_q <= {ctrl_i.nbytes, 3'b000};
            end
        end else if (bit_cnt_q == '0) begin  // one cycle after last bit
            busy_q <= 1'b0;
            csn_q  <= 1'b1;
        end else if (tick) begin
            prsc_cnt_q <= '0;
            phase_q    <= !phase_q;
            if (phase_q) begin
                bit_cnt_q <= bit_cnt_q - 7'd1;  // trailing edge closes the bit
            end
        end else begin
            prsc_cnt_q <= prsc_cnt_q + 3'd1;
        end
    end

    // ------------------------------------------------------------------------
    // shift registers
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (start_ok) begin
            tx_q <= spi_req_i.wdata;
        end else if (shift_en) begin
            tx_q <= {tx_q[`XIP_WDATA_W-2:0], 1'b0};  // next bit on trailing edge
        end
        if (sample_en) begin
            rx_q <= {rx_q[`XIP_DATA_W-2:0], spi_dat_i};  // sample on leading edge
        end
    end

    assign spi_csn_o       = csn_q;
    assign spi_clk_o       = ctrl_i.cpol ^ phase_q;  // idles at cpol
    assign spi_dat_o       = busy_q & tx_q[`XIP_WDATA_W-1];
    assign spi_rsp_o.busy  = busy_q;
    assign spi_rsp_o.rdata = rx_q;

endmodule

// File: xip_fetch.sv
// fetch arbiter, one access at a time, host holds the address until ack or err
// requests that come in while a fetch runs are dropped, nothing is queued
`timescale 1ns/1ns
`include "xip_macros.svh"

module xip_fetch (
    input  logic                     clk_i,
    input  logic                     rstn_i,
    input  xip_pkg::xip_ctrl_t       ctrl_i,
    input  logic                     direct_start_i,
    input  logic [2*`XIP_DATA_W-1:0] direct_frame_i,
    input  logic [`XIP_DATA_W-1:0]   acc_addr_i,
    input  logic                     acc_rden_i,
    input  logic                     acc_wren_i,
    input  xip_pkg::spi_rsp_t        spi_rsp_i,
    output xip_pkg::spi_req_t        spi_req_o,
    output logic [`XIP_DATA_W-1:0]   acc_data_o,
    output logic                     acc_ack_o,
    output logic                     acc_err_o,
    output logic                     fetch_busy_o
);

    xip_pkg::fetch_state_e          state_q, state_d;
    logic [`XIP_FLASH_ADDR_MSB:2]   addr_q;      // word address in flash
    logic                           page_hit;
    logic                           addr_load;
    logic [`XIP_DATA_W-1:0]         word_addr;
    logic [`XIP_DATA_W-1:0]         flash_addr;  // left aligned address bytes

    assign page_hit  = (acc_addr_i[`XIP_PAGE_MSB:`XIP_PAGE_LSB] == ctrl_i.page);
    assign word_addr = {{(`XIP_DATA_W-`XIP_FLASH_ADDR_MSB-1){1'b0}}, addr_q, 2'b00};

    always_comb begin
        case (ctrl_i.abytes)
            2'd0:    flash_addr = {word_addr[7:0], 24'h000000};
            2'd1:    flash_addr = {word_addr[15:0], 16'h0000};
            2'd2:    flash_addr = {word_addr[23:0], 8'h00};
            default: flash_addr = word_addr;
        endcase
    end

    // ------------------------------------------------------------------------
    // state register, forced to direct while xip is off
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state_q <= xip_pkg::S_DIRECT;
        end else if (!ctrl_i.enable || !ctrl_i.xip_en) begin
            state_q <= xip_pkg::S_DIRECT;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (addr_load) begin
            addr_q <= acc_addr_i[`XIP_FLASH_ADDR_MSB:2];  // byte lanes dropped
        end
    end

    always_comb begin
        state_d         = state_q;
        addr_load       = 1'b0;
        acc_data_o      = '0;
        acc_ack_o       = 1'b0;
        acc_err_o       = 1'b0;
        spi_req_o.start = 1'b0;
        spi_req_o.wdata = {ctrl_i.rd_cmd, flash_addr, {`XIP_DATA_W{1'b0}}};  // cmd, addr, dummy
        case (state_q)
            xip_pkg::S_DIRECT: begin
                spi_req_o.wdata = {direct_frame_i, 8'h00};  // msb aligned
                spi_req_o.start = direct_start_i;
                state_d         = xip_pkg::S_IDLE;          // only taken when xip on
            end
            xip_pkg::S_IDLE: begin
                if (page_hit && acc_rden_i) begin
                    addr_load = 1'b1;
                    state_d   = xip_pkg::S_TRIG;
                end else if (page_hit && acc_wren_i) begin
                    state_d = xip_pkg::S_ERROR;             // fetch port is read only
                end
            end
            xip_pkg::S_TRIG: begin
                spi_req_o.start = 1'b1;
                state_d         = xip_pkg::S_BUSY;
            end
            xip_pkg::S_BUSY: begin
                if (!spi_rsp_i.busy) begin
                    // first byte received lands in bits 7:0
                    acc_data_o = {spi_rsp_i.rdata[7:0], spi_rsp_i.rdata[15:8],
                                  spi_rsp_i.rdata[23:16], spi_rsp_i.rdata[31:24]};
                    acc_ack_o  = 1'b1;
                    state_d    = xip_pkg::S_IDLE;
                end
            end
            xip_pkg::S_ERROR: begin
                acc_err_o = 1'b1;
                state_d   = xip_pkg::S_IDLE;
            end
            default: state_d = xip_pkg::S_IDLE;
        endcase
    end

    assign fetch_busy_o = (state_q == xip_pkg::S_TRIG) || (state_q == xip_pkg::S_BUSY);

endmodule

// File: xip_regs.sv
// control port registers, word writes only, one cycle read latency
// data high is write-only, writing it fires a direct spi frame
`timescale 1ns/1ns
`include "xip_macros.svh"

module xip_regs (
    input  logic                         clk_i,
    input  logic                         rstn_i,
    input  xip_pkg::reg_idx_e            ct_idx_i,       // word index
    input  logic                         ct_rden_i,
    input  logic                         ct_wren_i,
    input  logic [`XIP_DATA_W-1:0]       ct_data_i,
    input  xip_pkg::spi_rsp_t            spi_rsp_i,      // busy and rx word
    input  logic                         fetch_busy_i,
    output logic [`XIP_DATA_W-1:0]       ct_data_o,
    output logic                         ct_ack_o,
    output xip_pkg::xip_ctrl_t           ctrl_o,
    output logic                         direct_start_o, // one cycle after hi write
    output logic [2*`XIP_DATA_W-1:0]     direct_frame_o  // {hi, lo}
);

    xip_pkg::xip_ctrl_t     ctrl_q;
    logic [`XIP_DATA_W-1:0] data_lo_q;
    logic [`XIP_DATA_W-1:0] data_hi_q;
    logic                   direct_start_q;
    logic [`XIP_DATA_W-1:0] ctrl_rd;  // ctrl plus live status

    // ------------------------------------------------------------------------
    // write decode
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            ctrl_q         <= '0;
            direct_start_q <= 1'b0;
        end else begin
            direct_start_q <= ct_wren_i && (ct_idx_i == xip_pkg::REG_DATA_HI);
            if (ct_wren_i && (ct_idx_i == xip_pkg::REG_CTRL)) begin
                ctrl_q          <= ct_data_i[`XIP_CTRL_W-1:0];
                ctrl_q.reserved <= 1'b0;  // cpha not implemented
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (ct_wren_i && (ct_idx_i == xip_pkg::REG_DATA_LO)) begin
            data_lo_q <= ct_data_i;
        end
        if (ct_wren_i && (ct_idx_i == xip_pkg::REG_DATA_HI)) begin
            data_hi_q <= ct_data_i;
        end
    end

    // ------------------------------------------------------------------------
    // read mux and acknowledge
    // ------------------------------------------------------------------------
    always_comb begin
        ctrl_rd                     = '0;
        ctrl_rd[`XIP_CTRL_W-1:0]    = ctrl_q;
        ctrl_rd[`XIP_STAT_PHY_BUSY] = spi_rsp_i.busy;
        ctrl_rd[`XIP_STAT_XIP_BUSY] = fetch_busy_i;
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            ct_ack_o  <= 1'b0;
            ct_data_o <= '0;
        end else begin
            ct_ack_o  <= ct_rden_i | ct_wren_i;  // any strobe acks next cycle
            ct_data_o <= '0;                     // zero outside the ack cycle
            if (ct_rden_i) begin
                case (ct_idx_i)
                    xip_pkg::REG_CTRL:    ct_data_o <= ctrl_rd;
                    xip_pkg::REG_DATA_LO: ct_data_o <= spi_rsp_i.rdata;
                    default:              ct_data_o <= '0;  // reserved, data hi wo
                endcase
            end
        end
    end

    assign ctrl_o         = ctrl_q;
    assign direct_start_o = direct_start_q;
    assign direct_frame_o = {data_hi_q, data_lo_q};

endmodule

// File: xip_pkg.sv
// types shared by the XIP controller blocks
// control bit 5 is reserved and always reads as zero
`include "xip_macros.svh"

package xip_pkg;

    // control register, bit 0 at the bottom
    typedef struct packed {
        logic       csen;      // drive chip select
        logic [3:0] page;      // fetch page nibble
        logic [7:0] rd_cmd;    // flash read opcode
        logic [1:0] abytes;    // address bytes minus one
        logic       xip_en;    // fetch mode on
        logic [3:0] nbytes;    // bytes per frame
        logic       reserved;  // was cpha, cpha 0 only
        logic       cpol;      // idle clock level
        logic [2:0] prsc;      // half bit = prsc+1 cycles
        logic       enable;    // block enable
    } xip_ctrl_t;

    typedef struct packed {
        logic                    start;  // one cycle pulse
        logic [`XIP_WDATA_W-1:0] wdata;  // msb goes out first
    } spi_req_t;

    typedef struct packed {
        logic                   busy;   // frame in progress
        logic [`XIP_DATA_W-1:0] rdata;  // last 32 rx bits
    } spi_rsp_t;

    typedef enum logic [2:0] {
        S_DIRECT, S_IDLE, S_TRIG, S_BUSY, S_ERROR
    } fetch_state_e;

    typedef enum logic [1:0] {
        REG_CTRL      = 2'd0,
        REG_STAT_RSVD = 2'd1,
        REG_DATA_LO   = 2'd2,
        REG_DATA_HI   = 2'd3
    } reg_idx_e;

endpackage

// File: xip_macros.svh
// fixed widths and bit positions of the XIP controller
// the flash page is the top nibble of the fetch address, flash space is 256 MB
`ifndef XIP_MACROS_SVH
`define XIP_MACROS_SVH

// ------------------------------------------------------------------------
// host and frame widths
// ------------------------------------------------------------------------
`define XIP_DATA_W          32  // host word
`define XIP_WDATA_W         72  // spi tx frame, nine bytes
`define XIP_CTRL_W          26  // implemented control bits

// ------------------------------------------------------------------------
// fetch address fields
// ------------------------------------------------------------------------
`define XIP_PAGE_MSB        31  // page nibble, compared to ctrl page
`define XIP_PAGE_LSB        28
`define XIP_FLASH_ADDR_MSB  27  // top bit sent to the flash

// ------------------------------------------------------------------------
// status bits merged into a control register read
// ------------------------------------------------------------------------
`define XIP_STAT_PHY_BUSY   30  // spi engine shifting
`define XIP_STAT_XIP_BUSY   31  // fetch in flight

`endif
